// ==== sim.f ====
rtl/snn_pkg.sv
rtl/param_regs.sv
rtl/tick_gen.sv
rtl/synapse.sv
rtl/lif_neuron.sv
rtl/snn_chain_top.sv
dv/snn_chain_tb.sv

// ==== dv/snn_chain_tb.sv ====
module snn_chain_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DECAY_SHIFT = 3;

    logic                              ep50trig;
    logic                              reset_global;
    logic                              sim_reset;
    logic                              param_load;
    snn_pkg::param_sel_e               param_sel;
    logic        [snn_pkg::DATA_W-1:0] param_data;
    logic                              spike_in;
    logic signed [snn_pkg::CUR_W-1:0]  syn_current1;
    logic signed [snn_pkg::CUR_W-1:0]  syn_current2;
    logic signed [snn_pkg::CUR_W-1:0]  scaled_current1;
    logic signed [snn_pkg::CUR_W-1:0]  scaled_current2;
    logic                              mid_spike;
    logic                              spike_out;

    int mismatch_errs = 0;
    int timeout_errs = 0;

    // reference state at its reset values
    logic        [snn_pkg::DATA_W-1:0] m_cnt = '0;
    logic        [snn_pkg::DATA_W-1:0] m_tp = snn_pkg::DEF_TICK_PERIOD;
    logic signed [snn_pkg::CUR_W-1:0]  m_w = snn_pkg::DEF_WEIGHT;
    logic signed [snn_pkg::DATA_W-1:0] m_gain = snn_pkg::DEF_GAIN;
    logic signed [snn_pkg::CUR_W-1:0]  m_th = snn_pkg::DEF_THRESHOLD;
    logic        [4:0]                 m_ls = snn_pkg::DEF_LEAK_SHIFT;
    logic                              m_pend [2] = '{1'b0, 1'b0};
    logic signed [snn_pkg::CUR_W-1:0]  m_cur [2] = '{0, 0};
    logic signed [snn_pkg::CUR_W-1:0]  m_mem [2] = '{0, 0};
    logic signed [snn_pkg::CUR_W-1:0]  m_scaled [2] = '{0, 0};
    logic                              m_spike [2] = '{1'b0, 1'b0};

    snn_chain_top #(.DECAY_SHIFT(DECAY_SHIFT)) dut_i (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .sim_reset       (sim_reset),
        .param_load      (param_load),
        .param_sel       (param_sel),
        .param_data      (param_data),
        .spike_in        (spike_in),
        .syn_current1    (syn_current1),
        .syn_current2    (syn_current2),
        .scaled_current1 (scaled_current1),
        .scaled_current2 (scaled_current2),
        .mid_spike       (mid_spike),
        .spike_out       (spike_out)
    );

    // 4 ns clock
    initial
    begin
        ep50trig = 1'b0;
        forever
        begin
            #2 ep50trig = ~ep50trig;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    // one clock edge of the whole network with inputs as seen at that edge
    function automatic void ref_step(input logic rst_g, input logic rst_s, input logic ld,
                                     input snn_pkg::param_sel_e sel,
                                     input logic [snn_pkg::DATA_W-1:0] data,
                                     input logic sin);
        logic                              tick_now;
        logic                              syn_in;
        logic                              spike_old1;
        logic signed [63:0]                prod;
        logic signed [snn_pkg::CUR_W-1:0]  scaled;
        logic signed [snn_pkg::CUR_W-1:0]  mem_nxt;
        // terminal count also ends a period cut short by a smaller tick_period
        tick_now = (m_cnt >= m_tp);
        // stage 2 input is the registered neuron 1 spike
        spike_old1 = m_spike[0];
        if (rst_g || rst_s)
        begin
            m_cnt = '0;
            for (int s = 0; s < 2; s++)
            begin
                m_pend[s] = 1'b0;
                m_cur[s] = '0;
                m_mem[s] = '0;
                m_scaled[s] = '0;
                m_spike[s] = 1'b0;
            end
        end
        else
        begin
            m_cnt = tick_now ? '0 : m_cnt + 1;
            for (int s = 0; s < 2; s++)
            begin
                syn_in = (s == 0) ? sin : spike_old1;
                if (tick_now)
                begin
                    // neuron sees the current from before this tick
                    prod = m_cur[s] * m_gain;
                    scaled = prod[snn_pkg::FRAC_BITS +: snn_pkg::CUR_W];
                    mem_nxt = m_mem[s] + scaled - (m_mem[s] >>> m_ls);
                    m_scaled[s] = scaled;
                    m_spike[s] = (mem_nxt >= m_th);
                    m_mem[s] = (m_spike[s] || mem_nxt < 0) ? '0 : mem_nxt;
                    m_cur[s] = m_cur[s] - (m_cur[s] >>> DECAY_SHIFT)
                               + ((m_pend[s] || syn_in) ? m_w : 0);
                    m_pend[s] = 1'b0;
                end
                else
                begin
                    m_spike[s] = 1'b0;
                    if (syn_in)
                    begin
                        m_pend[s] = 1'b1;
                    end
                end
            end
        end
        // parameters last since the network used the old ones
        if (rst_g)
        begin
            m_tp = snn_pkg::DEF_TICK_PERIOD;
            m_w = snn_pkg::DEF_WEIGHT;
            m_gain = snn_pkg::DEF_GAIN;
            m_th = snn_pkg::DEF_THRESHOLD;
            m_ls = snn_pkg::DEF_LEAK_SHIFT;
        end
        else if (ld)
        begin
            case (sel)
                snn_pkg::SEL_TICK_PERIOD: m_tp = data;
                snn_pkg::SEL_WEIGHT:      m_w = data;
                snn_pkg::SEL_GAIN:        m_gain = data;
                snn_pkg::SEL_THRESHOLD:   m_th = data;
                snn_pkg::SEL_LEAK_SHIFT:  m_ls = data[4:0];
                default:                  ;
            endcase
        end
    endfunction

    ////////////////////
    // checks
    ////////////////////

    task automatic check_current(input string name, input logic signed [snn_pkg::CUR_W-1:0] got,
                                 input logic signed [snn_pkg::CUR_W-1:0] exp);
        if (got !== exp)
        begin
            mismatch_errs++;
            $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_spike(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatch_errs++;
            $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // outputs settle after the rising edge so compare and step on the falling one
    always @(negedge ep50trig)
    begin
        check_current("syn_current1", syn_current1, m_cur[0]);
        check_current("syn_current2", syn_current2, m_cur[1]);
        check_current("scaled_current1", scaled_current1, m_scaled[0]);
        check_current("scaled_current2", scaled_current2, m_scaled[1]);
        check_spike("mid_spike", mid_spike, m_spike[0]);
        check_spike("spike_out", spike_out, m_spike[1]);
        ref_step(reset_global, sim_reset, param_load, param_sel, param_data, spike_in);
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic run_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge ep50trig);
            spike_in <= 1'b0;
        end
    endtask

    // density in percent per cycle
    task automatic run_random(input int cycles, input int density);
        repeat (cycles)
        begin
            @(posedge ep50trig);
            spike_in <= ($urandom_range(99) < density);
        end
        @(posedge ep50trig);
        spike_in <= 1'b0;
    endtask

    task automatic load_param(input snn_pkg::param_sel_e sel,
                              input logic [snn_pkg::DATA_W-1:0] data);
        @(posedge ep50trig);
        param_load <= 1'b1;
        param_sel <= sel;
        param_data <= data;
        @(posedge ep50trig);
        param_load <= 1'b0;
    endtask

    // polls on falling edges until syn_current1 leaves old_val
    task automatic wait_current1_not(input logic signed [snn_pkg::CUR_W-1:0] old_val,
                                     input int limit, input string what);
        int n;
        n = 0;
        do
        begin
            @(negedge ep50trig);
            n++;
        end
        while (syn_current1 == old_val && n < limit);
        if (syn_current1 == old_val)
        begin
            timeout_errs++;
            $display("Timeout: %s never came within %0d cycles", what, limit);
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial
    begin
        reset_global = 1'b1;
        sim_reset = 1'b0;
        param_load = 1'b0;
        param_sel = snn_pkg::SEL_TICK_PERIOD;
        param_data = '0;
        spike_in = 1'b0;
        void'($urandom(58));
        repeat (2) @(posedge ep50trig);
        reset_global <= 1'b0;

        // quiet network with defaults
        run_idle(50);

        // single pulse gives one weight step then decay
        @(posedge ep50trig);
        spike_in <= 1'b1;
        @(posedge ep50trig);
        spike_in <= 1'b0;
        wait_current1_not(0, 20, "syn_current1 step after a single pulse");
        check_current("syn_current1 step", syn_current1, snn_pkg::DEF_WEIGHT);
        wait_current1_not(snn_pkg::DEF_WEIGHT, 20, "syn_current1 decay");
        check_current("syn_current1 decay", syn_current1,
                      snn_pkg::DEF_WEIGHT - (snn_pkg::DEF_WEIGHT >>> DECAY_SHIFT));
        run_idle(40);

        // random trains at 30 % density
        run_random(2000, 30);

        // mid-run loads for a faster tick, inverted gain and easier firing
        load_param(snn_pkg::SEL_TICK_PERIOD, 32'd2);
        run_random(100, 30);
        load_param(snn_pkg::SEL_GAIN, -32'sd1536);
        load_param(snn_pkg::SEL_THRESHOLD, 32'sd8000);
        load_param(snn_pkg::SEL_LEAK_SHIFT, 32'd2);
        run_random(300, 30);
        // positive gain again so the lower threshold gets crossed
        load_param(snn_pkg::SEL_GAIN, 32'sd2048);
        run_random(300, 30);

        // code 6 names no register
        load_param(snn_pkg::param_sel_e'(3'd6), 32'd0);
        run_random(200, 30);

        // network reset keeps the loaded parameters
        @(posedge ep50trig);
        spike_in <= 1'b0;
        sim_reset <= 1'b1;
        @(posedge ep50trig);
        sim_reset <= 1'b0;
        spike_in <= 1'b1;
        @(posedge ep50trig);
        spike_in <= 1'b0;
        // tick_period 2 lands the step within a few cycles where 7 would not
        wait_current1_not(0, 5, "syn_current1 step at the short tick period after sim_reset");
        run_random(200, 30);
        run_idle(20);

        $display("errors: %0d mismatches, %0d timeouts", mismatch_errs, timeout_errs);
        if (mismatch_errs == 0 && timeout_errs == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/snn_chain_top.sv ====
module snn_chain_top #(
    parameter int DECAY_SHIFT = 3
) (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              sim_reset,
    input  logic                              param_load,
    input  snn_pkg::param_sel_e               param_sel,
    input  logic        [snn_pkg::DATA_W-1:0] param_data,
    input  logic                              spike_in,
    output logic signed [snn_pkg::CUR_W-1:0]  syn_current1,
    output logic signed [snn_pkg::CUR_W-1:0]  syn_current2,
    output logic signed [snn_pkg::CUR_W-1:0]  scaled_current1,
    output logic signed [snn_pkg::CUR_W-1:0]  scaled_current2,
    output logic                              mid_spike,
    output logic                              spike_out
);

    // host parameters, shared by both stages
    logic        [snn_pkg::DATA_W-1:0] tick_period;
    logic signed [snn_pkg::CUR_W-1:0]  weight;
    logic signed [snn_pkg::DATA_W-1:0] gain;
    logic signed [snn_pkg::CUR_W-1:0]  threshold;
    logic        [4:0]                 leak_shift;

    // neuron update enable
    logic tick;

    param_regs u_param_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .param_load   (param_load),
        .param_sel    (param_sel),
        .param_data   (param_data),
        .tick_period  (tick_period),
        .weight       (weight),
        .gain         (gain),
        .threshold    (threshold),
        .leak_shift   (leak_shift)
    );

    tick_gen u_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sim_reset    (sim_reset),
        .tick_period  (tick_period),
        .tick         (tick)
    );

    ////////////////////
    // stage 1, external input
    ////////////////////

    synapse #(.DECAY_SHIFT(DECAY_SHIFT)) u_synapse1 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sim_reset    (sim_reset),
        .tick         (tick),
        .spike_in     (spike_in),
        .weight       (weight),
        .current      (syn_current1)
    );

    lif_neuron u_neuron1 (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .sim_reset      (sim_reset),
        .tick           (tick),
        .current        (syn_current1),
        .gain           (gain),
        .threshold      (threshold),
        .leak_shift     (leak_shift),
        .scaled_current (scaled_current1),
        .spike          (mid_spike)
    );

    ////////////////////
    // stage 2, fed by neuron 1 spikes
    ////////////////////

    synapse #(.DECAY_SHIFT(DECAY_SHIFT)) u_synapse2 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sim_reset    (sim_reset),
        .tick         (tick),
        .spike_in     (mid_spike),
        .weight       (weight),
        .current      (syn_current2)
    );

    lif_neuron u_neuron2 (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .sim_reset      (sim_reset),
        .tick           (tick),
        .current        (syn_current2),
        .gain           (gain),
        .threshold      (threshold),
        .leak_shift     (leak_shift),
        .scaled_current (scaled_current2),
        .spike          (spike_out)
    );

endmodule

// ==== rtl/lif_neuron.sv ====
module lif_neuron (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              sim_reset,
    input  logic                              tick,
    input  logic signed [snn_pkg::CUR_W-1:0]  current,
    input  logic signed [snn_pkg::DATA_W-1:0] gain,
    input  logic signed [snn_pkg::CUR_W-1:0]  threshold,
    input  logic        [4:0]                 leak_shift,
    output logic signed [snn_pkg::CUR_W-1:0]  scaled_current,
    output logic                              spike
);

    ////////////////////
    // gain stage
    ////////////////////

    // full product, both operands signed
    logic signed [snn_pkg::CUR_W+snn_pkg::DATA_W-1:0] gain_prod;

    // product with the gain fraction removed
    logic signed [snn_pkg::CUR_W+snn_pkg::DATA_W-1:0] gain_frac;

    // low word of the scaled product
    logic signed [snn_pkg::CUR_W-1:0] scaled_next;

    assign gain_prod   = current * gain;
    assign gain_frac   = gain_prod >>> snn_pkg::FRAC_BITS;
    assign scaled_next = gain_frac[snn_pkg::CUR_W-1:0];

    ////////////////////
    // leaky membrane
    ////////////////////

    // membrane potential, kept at 0 or above
    logic signed [snn_pkg::CUR_W-1:0] membrane;

    // leak, membrane/2^leak_shift
    logic signed [snn_pkg::CUR_W-1:0] leak_term;

    // candidate membrane after this tick
    logic signed [snn_pkg::CUR_W-1:0] mem_next;

    // threshold crossed
    logic fire;

    assign leak_term = membrane >>> leak_shift;
    assign mem_next  = membrane + scaled_next - leak_term;
    assign fire      = (mem_next >= threshold);

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || sim_reset)
        begin
            scaled_current <= '0;
            membrane       <= '0;
            spike          <= 1'b0;
        end
        else if (tick)
        begin
            // uses the synapse current from before its own tick update
            scaled_current <= scaled_next;
            spike          <= fire;
            if (fire)
            begin
                // reset to rest after firing
                membrane <= '0;
            end
            else if (mem_next < 0)
            begin
                // floor, no hyperpolarization below rest
                membrane <= '0;
            end
            else
            begin
                membrane <= mem_next;
            end
        end
        else
        begin
            // spike lasts one cycle only
            spike <= 1'b0;
        end
    end

endmodule

// ==== rtl/synapse.sv ====
module synapse #(
    parameter int DECAY_SHIFT = 3
) (
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             sim_reset,
    input  logic                             tick,
    input  logic                             spike_in,
    input  logic signed [snn_pkg::CUR_W-1:0] weight,
    output logic signed [snn_pkg::CUR_W-1:0] current
);

    ////////////////////
    // spike capture
    ////////////////////

    // sticky flag, holds a spike seen between two ticks
    logic spike_pend;

    // spike counted in this tick, flagged earlier or arriving now
    logic spike_hit;

    assign spike_hit = spike_pend || spike_in;

    ////////////////////
    // current update
    ////////////////////

    // exponential decay step, current/2^DECAY_SHIFT
    logic signed [snn_pkg::CUR_W-1:0] decay_term;

    // weighted increment for this tick
    logic signed [snn_pkg::CUR_W-1:0] inc_term;

    // value the current takes at the end of a tick cycle
    logic signed [snn_pkg::CUR_W-1:0] current_next;

    assign decay_term   = current >>> DECAY_SHIFT;
    assign inc_term     = spike_hit ? weight : '0;
    assign current_next = current - decay_term + inc_term;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || sim_reset)
        begin
            spike_pend <= 1'b0;
            current    <= '0;
        end
        else if (tick)
        begin
            // flag consumed by this tick
            spike_pend <= 1'b0;
            current    <= current_next;
        end
        else if (spike_in)
        begin
            spike_pend <= 1'b1;
        end
    end

endmodule

// ==== rtl/tick_gen.sv ====
module tick_gen (
    input  logic                       ep50trig,
    input  logic                       reset_global,
    input  logic                       sim_reset,
    input  logic [snn_pkg::DATA_W-1:0] tick_period,
    output logic                       tick
);

    ////////////////////
    // neuron update tick
    ////////////////////

    // cycle count inside the current tick period
    logic [snn_pkg::DATA_W-1:0] tick_cnt;

    // one-cycle enable at the terminal count
    // >= also ends a period when the host shrinks it below the running count
    assign tick = (tick_cnt >= tick_period);

    // counts 0 .. tick_period, so tick_period+1 cycles per tick
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || sim_reset)
        begin
            tick_cnt <= '0;
        end
        else if (tick)
        begin
            // restart the period
            tick_cnt <= '0;
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/param_regs.sv ====
module param_regs (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              param_load,
    input  snn_pkg::param_sel_e               param_sel,
    input  logic        [snn_pkg::DATA_W-1:0] param_data,
    output logic        [snn_pkg::DATA_W-1:0] tick_period,
    output logic signed [snn_pkg::CUR_W-1:0]  weight,
    output logic signed [snn_pkg::DATA_W-1:0] gain,
    output logic signed [snn_pkg::CUR_W-1:0]  threshold,
    output logic        [4:0]                 leak_shift
);

    ////////////////////
    // host parameter registers
    ////////////////////

    // one strobe, the select code picks the target
    // new value seen by the network from the next cycle on
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            tick_period <= snn_pkg::DEF_TICK_PERIOD;
            weight      <= snn_pkg::DEF_WEIGHT;
            gain        <= snn_pkg::DEF_GAIN;
            threshold   <= snn_pkg::DEF_THRESHOLD;
            leak_shift  <= snn_pkg::DEF_LEAK_SHIFT;
        end
        else if (param_load)
        begin
            case (param_sel)
                snn_pkg::SEL_TICK_PERIOD:
                begin
                    tick_period <= param_data;
                end
                snn_pkg::SEL_WEIGHT:
                begin
                    weight <= param_data;
                end
                snn_pkg::SEL_GAIN:
                begin
                    // signed, fraction of 1024
                    gain <= param_data;
                end
                snn_pkg::SEL_THRESHOLD:
                begin
                    threshold <= param_data;
                end
                snn_pkg::SEL_LEAK_SHIFT:
                begin
                    // only the low bits mean anything for a 32-bit shift
                    leak_shift <= param_data[4:0];
                end
                default:
                begin
                    // unused codes leave every register alone
                end
            endcase
        end
    end

endmodule

// ==== rtl/snn_pkg.sv ====
package snn_pkg;

    ////////////////////
    // parameter select codes
    ////////////////////

    // host select code, sent along with the load strobe
    typedef enum logic [2:0] {
        SEL_TICK_PERIOD = 3'd0,
        SEL_WEIGHT      = 3'd1,
        SEL_GAIN        = 3'd2,
        SEL_THRESHOLD   = 3'd3,
        SEL_LEAK_SHIFT  = 3'd4
    } param_sel_e;

    ////////////////////
    // widths
    ////////////////////

    // host data word
    localparam int DATA_W = 32;

    // synaptic current and membrane, both signed
    localparam int CUR_W = 32;

    // gain fraction, 1024 stands for 1.0
    localparam int FRAC_BITS = 10;

    ////////////////////
    // reset defaults
    ////////////////////

    // tick every 8 cycles
    localparam logic [DATA_W-1:0] DEF_TICK_PERIOD = 32'd7;

    // increment per captured spike
    localparam logic signed [CUR_W-1:0] DEF_WEIGHT = 32'sd4096;

    // unity gain
    localparam logic signed [DATA_W-1:0] DEF_GAIN = 32'sd1024;

    // firing level of the membrane
    localparam logic signed [CUR_W-1:0] DEF_THRESHOLD = 32'sd20000;

    // membrane leaks 1/16 per tick
    localparam logic [4:0] DEF_LEAK_SHIFT = 5'd4;

endpackage
